// ==== common/fetch_defs.svh ====
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// fetch address width
`define PC_WIDTH 32

// l1i geometry, 16 sets of 16-byte lines
`define LG_L1I_SETS 4
`define LG_CL_BYTES 4
`define WORDS_PER_CL 4
`define CL_BITS 128

// whatever is left above set index and line offset
`define TAG_BITS (`PC_WIDTH - `LG_L1I_SETS - `LG_CL_BYTES)

// fetch queue depth, 8 entries
`define LG_FQ_ENTRIES 3

`endif

// ==== common/insn_pkg.sv ====
`include "fetch_defs.svh"

package insn_pkg;

   // i-type layout, used for the link register tests
   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   // j-type layout, immediate bits are scattered
   typedef struct packed {
      logic        imm20;
      logic [9:0]  imm10_1;
      logic        imm11;
      logic [7:0]  imm19_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } j_fmt_t;

   typedef union packed {
      i_fmt_t i_fmt;
      j_fmt_t j_fmt;
   } rv_insn_u;

   typedef enum logic [2:0] {
      PD_NONE    = 3'd0,
      PD_COND_BR = 3'd1,
      PD_RET     = 3'd2,
      PD_J       = 3'd3,
      PD_JR      = 3'd4,
      PD_JAL     = 3'd5,
      PD_JALR    = 3'd6
   } pd_class_e;

   typedef struct packed {
      logic [`PC_WIDTH-1:0] pc;
      rv_insn_u             insn;
      logic                 pred_taken;
      logic [`PC_WIDTH-1:0] pred_target;
      pd_class_e            pd;
   } fq_entry_t;

   typedef struct packed {
      logic                 valid;
      logic [`PC_WIDTH-1:0] pc;
   } redirect_t;

endpackage

// ==== common/mem_pkg.sv ====
`include "fetch_defs.svh"

package mem_pkg;

   // line fill request, addr is line aligned
   typedef struct packed {
      logic                 valid;
      logic [`PC_WIDTH-1:0] addr;
   } mem_req_t;

   // whole line comes back in one beat
   typedef struct packed {
      logic                valid;
      logic [`CL_BITS-1:0] data;
   } mem_rsp_t;

endpackage

// ==== icache/predecode.sv ====
`timescale 1ns/100ps

module predecode
(
   input  insn_pkg::rv_insn_u  insn,
   output insn_pkg::pd_class_e pd
);
   import insn_pkg::*;

   logic rd_is_link;
   logic rs1_is_link;

   // x1 and x5 both count as link registers
   assign rd_is_link  = (insn.i_fmt.rd == 5'd1) || (insn.i_fmt.rd == 5'd5);
   assign rs1_is_link = (insn.i_fmt.rs1 == 5'd1) || (insn.i_fmt.rs1 == 5'd5);

   always_comb
   begin
      pd = PD_NONE;
      case (insn.i_fmt.opcode)
         7'h63:
         begin
            pd = PD_COND_BR;
         end
         7'h67: // jalr family
         begin
            if (insn.i_fmt.rd == 5'd0)
            begin
               pd = rs1_is_link ? PD_RET : PD_JR;
            end
            else
            begin
               pd = PD_JALR;
            end
         end
         7'h6f:
         begin
            pd = rd_is_link ? PD_JAL : PD_J; // plain j writes x0
         end
         default:
         begin
            pd = PD_NONE;
         end
      endcase
   end

endmodule

// ==== icache/icache_arrays.sv ====
`timescale 1ns/100ps
`include "fetch_defs.svh"

module icache_arrays
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic [`LG_L1I_SETS-1:0]   lookup_idx,
   input  logic [`TAG_BITS-1:0]      lookup_tag,
   input  logic [1:0]                word_sel,
   input  logic                      sweep_en,
   input  logic [`LG_L1I_SETS-1:0]   sweep_idx,
   input  logic [`PC_WIDTH-1:0]      fill_addr,
   input  mem_pkg::mem_rsp_t         mem_rsp,
   output logic                      hit,
   output insn_pkg::rv_insn_u        word,
   output insn_pkg::pd_class_e       pd
);
   import insn_pkg::*;

   localparam SETS   = 1 << `LG_L1I_SETS;
   localparam IDX_LO = `LG_CL_BYTES;
   localparam TAG_LO = `LG_CL_BYTES + `LG_L1I_SETS;

   logic [SETS-1:0]                 valid_mem;
   logic [`TAG_BITS-1:0]            tag_mem [SETS];
   logic [`CL_BITS-1:0]             line_mem [SETS];
   pd_class_e [`WORDS_PER_CL-1:0]   pd_mem [SETS];

   pd_class_e [`WORDS_PER_CL-1:0]   fill_pd;
   logic [`LG_L1I_SETS-1:0]         fill_idx;

   logic                            r_valid;
   logic [`TAG_BITS-1:0]            r_tag;
   logic [`TAG_BITS-1:0]            r_lookup_tag;
   logic [`CL_BITS-1:0]             r_line;
   pd_class_e [`WORDS_PER_CL-1:0]   r_pd_line;
   logic [1:0]                      r_word_sel;

   assign fill_idx = fill_addr[TAG_LO-1:IDX_LO];

   // classify the incoming line while it is written
   for (genvar i = 0; i < `WORDS_PER_CL; i++)
   begin : g_fill_pd
      predecode u_predecode
      (
         .insn (mem_rsp.data[32*i +: 32]),
         .pd   (fill_pd[i])
      );
   end

   always_ff @(posedge clk)
   begin
      if (mem_rsp.valid)
      begin
         valid_mem[fill_idx] <= 1'b1;
         tag_mem[fill_idx]   <= fill_addr[`PC_WIDTH-1:TAG_LO];
         line_mem[fill_idx]  <= mem_rsp.data;
         pd_mem[fill_idx]    <= fill_pd;
      end
      else if (sweep_en)
      begin
         valid_mem[sweep_idx] <= 1'b0; // one set per cycle
      end
   end

   // registered read port
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_valid <= 1'b0;
      end
      else
      begin
         r_valid <= valid_mem[lookup_idx];
      end
   end

   always_ff @(posedge clk)
   begin
      r_tag        <= tag_mem[lookup_idx];
      r_line       <= line_mem[lookup_idx];
      r_pd_line    <= pd_mem[lookup_idx];
      r_lookup_tag <= lookup_tag;
      r_word_sel   <= word_sel;
   end

   assign hit  = r_valid && (r_tag == r_lookup_tag);
   assign word = r_line[32*r_word_sel +: 32];
   assign pd   = r_pd_line[r_word_sel];

endmodule

// ==== rtl/fetch_queue.sv ====
`timescale 1ns/100ps
`include "fetch_defs.svh"

module fetch_queue
(
   input  logic                clk,
   input  logic                reset,
   input  logic                clear,
   input  logic                push,
   input  insn_pkg::fq_entry_t push_entry,
   input  logic                pop,
   output insn_pkg::fq_entry_t head,
   output logic                empty,
   output logic                full
);
   import insn_pkg::*;

   localparam ENTRIES = 1 << `LG_FQ_ENTRIES;

   fq_entry_t mem [ENTRIES];

   // extra msb tells full from empty
   logic [`LG_FQ_ENTRIES:0] r_head_ptr;
   logic [`LG_FQ_ENTRIES:0] r_tail_ptr;

   assign empty = (r_head_ptr == r_tail_ptr);
   assign full  = (r_head_ptr[`LG_FQ_ENTRIES] != r_tail_ptr[`LG_FQ_ENTRIES]) &&
                  (r_head_ptr[`LG_FQ_ENTRIES-1:0] == r_tail_ptr[`LG_FQ_ENTRIES-1:0]);

   assign head = mem[r_head_ptr[`LG_FQ_ENTRIES-1:0]];

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         mem[r_tail_ptr[`LG_FQ_ENTRIES-1:0]] <= push_entry;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         // clear wins over a push or pop in the same cycle
         r_head_ptr <= '0;
         r_tail_ptr <= '0;
      end
      else
      begin
         if (push)
         begin
            r_tail_ptr <= r_tail_ptr + 1'b1;
         end
         if (pop)
         begin
            r_head_ptr <= r_head_ptr + 1'b1;
         end
      end
   end

endmodule

// ==== rtl/fetch_ctrl.sv ====
`timescale 1ns/100ps
`include "fetch_defs.svh"

module fetch_ctrl
(
   input  logic                      clk,
   input  logic                      reset,
   input  insn_pkg::redirect_t       restart,
   output logic                      restart_ack,
   input  logic                      flush_req,
   output logic                      flush_complete,
   output mem_pkg::mem_req_t         mem_req,
   input  logic                      mem_rsp_valid,
   input  logic                      hit,
   input  insn_pkg::rv_insn_u        word,
   input  insn_pkg::pd_class_e       pd,
   input  logic                      fq_full,
   output logic [`LG_L1I_SETS-1:0]   lookup_idx,
   output logic [`TAG_BITS-1:0]      lookup_tag,
   output logic [1:0]                word_sel,
   output logic                      sweep_en,
   output logic [`LG_L1I_SETS-1:0]   sweep_idx,
   output logic [`PC_WIDTH-1:0]      fill_addr,
   output logic                      push,
   output insn_pkg::fq_entry_t       push_entry,
   output logic                      fq_clear
);
   import insn_pkg::*;
   import mem_pkg::*;

   localparam IDX_LO = `LG_CL_BYTES;
   localparam TAG_LO = `LG_CL_BYTES + `LG_L1I_SETS;

   typedef enum logic [2:0] {
      S_FLUSH,
      S_IDLE,
      S_ACTIVE,
      S_RELOAD_WAIT,
      S_RELOAD_TURN,
      S_WAIT_NOT_FULL
   } state_t;

   state_t                   r_state, n_state;
   logic [`PC_WIDTH-1:0]     r_pc, n_pc;
   logic [`PC_WIDTH-1:0]     r_cache_pc, n_cache_pc; // pc of the lookup in flight
   logic [`PC_WIDTH-1:0]     r_miss_pc, n_miss_pc;
   logic [`PC_WIDTH-1:0]     r_restart_pc, t_restart_pc;
   logic [`PC_WIDTH-1:0]     t_lookup_pc;
   logic [`PC_WIDTH-1:0]     t_jal_simm;
   logic                     r_req, n_req;
   logic                     r_bubble, n_bubble;
   logic                     r_restart_req, n_restart_req;
   logic                     r_flush_req, n_flush_req;
   logic                     r_restart_ack, n_restart_ack;
   logic                     r_flush_complete, n_flush_complete;
   logic [`LG_L1I_SETS-1:0]  r_sweep_idx, n_sweep_idx;
   mem_req_t                 r_mem_req, n_mem_req;
   logic                     t_hit;
   logic                     t_miss;
   logic                     t_is_jump;
   logic                     t_can_redirect;

   assign t_hit     = r_req && hit;
   assign t_miss    = r_req && !hit;
   assign t_is_jump = (pd == PD_JAL) || (pd == PD_J);

   // jal offset from the scattered j-type fields
   assign t_jal_simm = {{(`PC_WIDTH-20){word.j_fmt.imm20}}, word.j_fmt.imm19_12,
                        word.j_fmt.imm11, word.j_fmt.imm10_1, 1'b0};

   assign t_restart_pc = restart.valid ? restart.pc : r_restart_pc;

   always_comb
   begin
      push_entry.pc          = r_cache_pc;
      push_entry.insn        = word;
      push_entry.pred_taken  = t_is_jump;
      push_entry.pred_target = t_is_jump ? r_cache_pc + t_jal_simm : r_cache_pc + 'd4;
      push_entry.pd          = pd;
   end

   always_comb
   begin
      n_state          = r_state;
      n_pc             = r_pc;
      n_cache_pc       = r_cache_pc;
      n_miss_pc        = r_miss_pc;
      n_req            = 1'b0;
      n_bubble         = 1'b0;
      n_restart_req    = r_restart_req | restart.valid;
      n_flush_req      = r_flush_req | flush_req;
      n_restart_ack    = 1'b0;
      n_flush_complete = 1'b0;
      n_sweep_idx      = r_sweep_idx;
      n_mem_req        = '{valid: 1'b0, addr: r_mem_req.addr};
      t_lookup_pc      = '0;
      sweep_en         = 1'b0;
      push             = 1'b0;
      fq_clear         = 1'b0;
      t_can_redirect   = 1'b0;

      case (r_state)
         S_FLUSH:
         begin
            sweep_en    = 1'b1;
            n_sweep_idx = r_sweep_idx + 1'b1;
            if (&r_sweep_idx)
            begin
               n_flush_complete = 1'b1;
               n_state          = S_IDLE;
            end
         end
         S_IDLE:
         begin
            t_can_redirect = 1'b1;
         end
         S_ACTIVE:
         begin
            t_can_redirect = 1'b1;
            t_lookup_pc    = r_pc; // next sequential lookup
            n_cache_pc     = r_pc;
            n_req          = 1'b1;
            n_pc           = r_pc + 'd4;
            if (r_bubble)
            begin
               // drop the lookup behind a taken jump
            end
            else if (t_miss)
            begin
               n_mem_req.valid = 1'b1;
               n_mem_req.addr  = {r_cache_pc[`PC_WIDTH-1:IDX_LO], {IDX_LO{1'b0}}};
               n_miss_pc       = r_cache_pc;
               n_pc            = r_pc;
               n_req           = 1'b0;
               n_state         = S_RELOAD_WAIT;
            end
            else if (t_hit && !fq_full)
            begin
               push = 1'b1;
               if (t_is_jump)
               begin
                  n_pc     = push_entry.pred_target;
                  n_bubble = 1'b1;
               end
            end
            else if (t_hit)
            begin
               n_miss_pc = r_cache_pc; // stalled pc is looked up again later
               n_pc      = r_pc;
               n_req     = 1'b0;
               n_state   = S_WAIT_NOT_FULL;
            end
         end
         S_RELOAD_WAIT:
         begin
            if (mem_rsp_valid)
            begin
               n_state = S_RELOAD_TURN;
            end
         end
         S_RELOAD_TURN, S_WAIT_NOT_FULL:
         begin
            t_can_redirect = 1'b1;
            t_lookup_pc    = r_miss_pc;
            if (!fq_full)
            begin
               n_cache_pc = r_miss_pc;
               n_req      = 1'b1;
               n_state    = S_ACTIVE;
            end
         end
         default:
         begin
            n_state = S_IDLE;
         end
      endcase

      // a pending flush goes before a restart and both drop this cycle's fetch
      if (t_can_redirect && n_flush_req)
      begin
         n_flush_req     = 1'b0;
         fq_clear        = 1'b1;
         push            = 1'b0;
         n_req           = 1'b0;
         n_bubble        = 1'b0;
         n_mem_req.valid = 1'b0;
         n_sweep_idx     = '0;
         n_state         = S_FLUSH;
      end
      else if (t_can_redirect && n_restart_req)
      begin
         n_restart_req   = 1'b0;
         n_restart_ack   = 1'b1;
         fq_clear        = 1'b1;
         push            = 1'b0;
         n_req           = 1'b0;
         n_bubble        = 1'b0;
         n_mem_req.valid = 1'b0;
         n_pc            = t_restart_pc;
         n_state         = S_ACTIVE;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state          <= S_FLUSH; // invalidate every set first
         r_req            <= 1'b0;
         r_bubble         <= 1'b0;
         r_restart_req    <= 1'b0;
         r_flush_req      <= 1'b0;
         r_restart_ack    <= 1'b0;
         r_flush_complete <= 1'b0;
         r_sweep_idx      <= '0;
         r_mem_req        <= '0;
      end
      else
      begin
         r_state          <= n_state;
         r_req            <= n_req;
         r_bubble         <= n_bubble;
         r_restart_req    <= n_restart_req;
         r_flush_req      <= n_flush_req;
         r_restart_ack    <= n_restart_ack;
         r_flush_complete <= n_flush_complete;
         r_sweep_idx      <= n_sweep_idx;
         r_mem_req        <= n_mem_req;
      end
   end

   always_ff @(posedge clk)
   begin
      r_pc         <= n_pc;
      r_cache_pc   <= n_cache_pc;
      r_miss_pc    <= n_miss_pc;
      r_restart_pc <= t_restart_pc;
   end

   assign lookup_idx     = t_lookup_pc[TAG_LO-1:IDX_LO];
   assign lookup_tag     = t_lookup_pc[`PC_WIDTH-1:TAG_LO];
   assign word_sel       = t_lookup_pc[IDX_LO-1:2];
   assign sweep_idx      = r_sweep_idx;
   assign fill_addr      = r_mem_req.addr; // held until the response arrives
   assign mem_req        = r_mem_req;
   assign restart_ack    = r_restart_ack;
   assign flush_complete = r_flush_complete;

endmodule

// ==== rtl/l1i_fetch.sv ====
`timescale 1ns/100ps
`include "fetch_defs.svh"

module l1i_fetch
(
   input  logic                clk,
   input  logic                reset,
   input  insn_pkg::redirect_t restart,
   output logic                restart_ack,
   input  logic                flush_req,
   output logic                flush_complete,
   output mem_pkg::mem_req_t   mem_req,
   input  mem_pkg::mem_rsp_t   mem_rsp,
   output insn_pkg::fq_entry_t insn,
   output logic                insn_valid,
   input  logic                insn_ack
);
   import insn_pkg::*;

   logic [`LG_L1I_SETS-1:0] lookup_idx;
   logic [`TAG_BITS-1:0]    lookup_tag;
   logic [1:0]              word_sel;
   logic                    sweep_en;
   logic [`LG_L1I_SETS-1:0] sweep_idx;
   logic [`PC_WIDTH-1:0]    fill_addr;
   logic                    hit;
   rv_insn_u                word;
   pd_class_e               pd;
   logic                    push;
   fq_entry_t               push_entry;
   logic                    fq_clear;
   logic                    fq_full;
   logic                    fq_empty;

   fetch_ctrl u_fetch_ctrl
   (
      .clk            (clk),
      .reset          (reset),
      .restart        (restart),
      .restart_ack    (restart_ack),
      .flush_req      (flush_req),
      .flush_complete (flush_complete),
      .mem_req        (mem_req),
      .mem_rsp_valid  (mem_rsp.valid),
      .hit            (hit),
      .word           (word),
      .pd             (pd),
      .fq_full        (fq_full),
      .lookup_idx     (lookup_idx),
      .lookup_tag     (lookup_tag),
      .word_sel       (word_sel),
      .sweep_en       (sweep_en),
      .sweep_idx      (sweep_idx),
      .fill_addr      (fill_addr),
      .push           (push),
      .push_entry     (push_entry),
      .fq_clear       (fq_clear)
   );

   icache_arrays u_icache_arrays
   (
      .clk        (clk),
      .reset      (reset),
      .lookup_idx (lookup_idx),
      .lookup_tag (lookup_tag),
      .word_sel   (word_sel),
      .sweep_en   (sweep_en),
      .sweep_idx  (sweep_idx),
      .fill_addr  (fill_addr),
      .mem_rsp    (mem_rsp),
      .hit        (hit),
      .word       (word),
      .pd         (pd)
   );

   fetch_queue u_fetch_queue
   (
      .clk        (clk),
      .reset      (reset),
      .clear      (fq_clear),
      .push       (push),
      .push_entry (push_entry),
      .pop        (insn_ack),
      .head       (insn),
      .empty      (fq_empty),
      .full       (fq_full)
   );

   assign insn_valid = !fq_empty;

endmodule

// ==== verification/tb_l1i_fetch.sv ====
`timescale 1ns/100ps
`include "fetch_defs.svh"

module tb_l1i_fetch;
   import insn_pkg::*;
   import mem_pkg::*;

   localparam logic [31:0] START_PC = 32'h0000_1000;
   localparam int CYCLE_LIMIT = 4000;
   localparam int WAIT_LIMIT  = 400;

   logic      clk = 1'b0;
   logic      reset;
   redirect_t restart;
   logic      restart_ack;
   logic      flush_req;
   logic      flush_complete;
   mem_req_t  mem_req;
   mem_rsp_t  mem_rsp;
   fq_entry_t insn;
   logic      insn_valid;
   logic      insn_ack;

   logic                 ack_enable;
   logic                 restarted;    // first restart has been driven
   logic                 hit_expected; // no line fill may be requested
   string                test_name;
   int                   cycle_count = 0;
   int                   req_count = 0;
   int                   rsp_wait = 0;
   logic [31:0]          rsp_addr = '0;
   int                   req_base;
   logic [`PC_WIDTH-1:0] exp_pc;
   int                   pop_count;
   int                   jal_pops;
   int                   j_pops;
   int                   flush_count;
   logic [31:0]          exp_word;
   logic                 exp_taken;
   logic [31:0]          exp_target;
   pd_class_e            exp_class;

   l1i_fetch u_dut
   (
      .clk            (clk),
      .reset          (reset),
      .restart        (restart),
      .restart_ack    (restart_ack),
      .flush_req      (flush_req),
      .flush_complete (flush_complete),
      .mem_req        (mem_req),
      .mem_rsp        (mem_rsp),
      .insn           (insn),
      .insn_valid     (insn_valid),
      .insn_ack       (insn_ack)
   );

   always #20 clk = ~clk;

   // offset of the jump at addr or zero
   function automatic logic [31:0] jump_offset(input logic [31:0] addr);
      case (addr)
         32'h0000_1018: jump_offset = 32'h0000_0040;
         32'h0000_1070: jump_offset = 32'hffff_ffa0; // back to 0x1010
         default:       jump_offset = 32'h0;
      endcase
   endfunction

   function automatic logic [4:0] jump_rd(input logic [31:0] addr);
      jump_rd = (addr == 32'h0000_1018) ? 5'd1 : 5'd0; // jal ra at 0x1018 and a plain j
   endfunction

   function automatic logic [31:0] mem_word(input logic [31:0] addr);
      logic [31:0] off;
      logic [11:0] folded;
      off    = jump_offset(addr);
      folded = addr[13:2] ^ addr[25:14] ^ {6'd0, addr[31:26]}; // word address in 12 bits
      if (off != 32'h0)
      begin
         mem_word = {off[20], off[10:1], off[11], off[19:12], jump_rd(addr), 7'h6f};
      end
      else
      begin
         mem_word = {folded, 5'd0, 3'd0, 5'd10, 7'h13}; // addi to x10 from x0
      end
   endfunction

   function automatic logic [127:0] line_data(input logic [31:0] addr);
      line_data = {mem_word(addr + 12), mem_word(addr + 8), mem_word(addr + 4), mem_word(addr)};
   endfunction

   task automatic report_error(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string test, input string field,
                                  input logic [31:0] expected, input logic [31:0] actual);
      report_error($sformatf("ERR %s %s expected %h actual %h", test, field, expected, actual));
   endtask

   // expected head entry for the model pc
   always_comb
   begin
      exp_word   = mem_word(exp_pc);
      exp_taken  = (jump_offset(exp_pc) != 32'h0);
      exp_target = exp_taken ? exp_pc + jump_offset(exp_pc) : exp_pc + 32'd4;
      if (!exp_taken)
         exp_class = PD_NONE;
      else if (jump_rd(exp_pc) == 5'd0)
         exp_class = PD_J;
      else
         exp_class = PD_JAL;
   end

   always @(posedge clk)
   begin
      if (reset)
      begin
         exp_pc      <= '0;
         pop_count   <= 0;
         jal_pops    <= 0;
         j_pops      <= 0;
         flush_count <= 0;
      end
      else
      begin
         if (flush_complete)
            flush_count <= flush_count + 1;
         if (restart.valid)
         begin
            exp_pc <= restart.pc;
         end
         else if (insn_ack)
         begin
            exp_pc    <= exp_target; // next pc of the model stream
            pop_count <= pop_count + 1;
            if (exp_class == PD_JAL)
               jal_pops <= jal_pops + 1;
            if (exp_class == PD_J)
               j_pops <= j_pops + 1;
         end
      end
   end

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT)
         report_error("timeout, the run did not finish within the cycle limit");
   end

   // memory model with one fill outstanding at a time
   always @(negedge clk)
   begin
      mem_rsp.valid = 1'b0;
      if (rsp_wait != 0)
      begin
         rsp_wait = rsp_wait - 1;
         if (rsp_wait == 0)
         begin
            mem_rsp.valid = 1'b1;
            mem_rsp.data  = line_data(rsp_addr);
         end
      end
      if (!reset && mem_req.valid)
      begin
         assert (rsp_wait == 0)
            else report_error("a second memory request came while a fill was outstanding");
         rsp_addr  = mem_req.addr;
         rsp_wait  = $urandom_range(6, 1);
         req_count = req_count + 1;
      end
   end

   always @(negedge clk)
   begin
      insn_ack = ack_enable && insn_valid && ($urandom_range(3, 0) != 0); // random ack gaps
   end

   a_quiet_before_restart: assert property (@(posedge clk) disable iff (reset)
      !restarted |-> (!insn_valid && !mem_req.valid))
      else report_error("queue output or memory request active before the first restart");

   a_single_flush_done: assert property (@(posedge clk) disable iff (reset)
      (flush_complete && !restarted) |-> (flush_count == 0))
      else report_error("flush_complete pulsed more than once after reset");

   a_pop_pc: assert property (@(posedge clk) disable iff (reset)
      insn_ack |-> (insn.pc == exp_pc))
      else report_mismatch(test_name, "pc", $sampled(exp_pc), $sampled(insn.pc));

   a_pop_word: assert property (@(posedge clk) disable iff (reset)
      insn_ack |-> (insn.insn == exp_word))
      else report_mismatch(test_name, "insn", $sampled(exp_word), $sampled(insn.insn));

   a_pop_taken: assert property (@(posedge clk) disable iff (reset)
      insn_ack |-> (insn.pred_taken == exp_taken))
      else report_mismatch(test_name, "pred_taken", $sampled(exp_taken),
                           $sampled(insn.pred_taken));

   a_pop_target: assert property (@(posedge clk) disable iff (reset)
      insn_ack |-> (insn.pred_target == exp_target))
      else report_mismatch(test_name, "pred_target", $sampled(exp_target),
                           $sampled(insn.pred_target));

   a_pop_class: assert property (@(posedge clk) disable iff (reset)
      insn_ack |-> (insn.pd == exp_class))
      else report_mismatch(test_name, "pd", {29'd0, $sampled(exp_class)},
                           {29'd0, $sampled(insn.pd)});

   a_no_refill: assert property (@(posedge clk) disable iff (reset)
      hit_expected |-> !mem_req.valid)
      else report_error("memory request issued for a line that should still be cached");

   task automatic wait_for_flush_done();
      int waited;
      waited = 0;
      while (!flush_complete)
      begin
         @(negedge clk);
         waited++;
         if (waited > WAIT_LIMIT)
            report_error("flush_complete never pulsed");
      end
   endtask

   task automatic send_restart(input logic [31:0] pc);
      int waited;
      waited     = 0;
      ack_enable = 1'b0; // stop popping before the queue gets cleared
      @(negedge clk);
      restart.valid = 1'b1;
      restart.pc    = pc;
      restarted     = 1'b1;
      @(negedge clk);
      restart.valid = 1'b0;
      while (!restart_ack)
      begin
         @(negedge clk);
         waited++;
         if (waited > WAIT_LIMIT)
            report_error("restart_ack never pulsed");
      end
      @(negedge clk);
      assert (!restart_ack) else report_error("restart_ack stayed high for more than a cycle");
      ack_enable = 1'b1;
   endtask

   task automatic wait_for_fill(input int base, input logic [31:0] pc);
      int waited;
      waited = 0;
      while (req_count == base)
      begin
         @(negedge clk);
         waited++;
         if (waited > WAIT_LIMIT)
            report_error("no memory request after a restart to an uncached line");
      end
      assert (rsp_addr == {pc[31:4], 4'h0})
         else report_mismatch(test_name, "mem_req addr", {pc[31:4], 4'h0}, rsp_addr);
   endtask

   task automatic wait_for_pops(input int count);
      int target;
      int waited;
      target = pop_count + count;
      waited = 0;
      while (pop_count < target)
      begin
         @(negedge clk);
         waited++;
         if (waited > WAIT_LIMIT)
            report_error("fetch stream stopped before the expected number of entries");
      end
   endtask

   initial
   begin
      void'($urandom(32'h80f5_7493));
      reset        = 1'b1;
      restart      = '0;
      flush_req    = 1'b0;
      insn_ack     = 1'b0;
      mem_rsp      = '0;
      ack_enable   = 1'b0;
      restarted    = 1'b0;
      hit_expected = 1'b0;
      test_name    = "reset_sweep";
      repeat (2) @(negedge clk);
      reset = 1'b0;

      wait_for_flush_done();
      repeat (10) @(negedge clk);
      assert (flush_count == 1)
         else report_mismatch(test_name, "flush pulses", 32'd1, flush_count);

      test_name = "cold_fetch";
      req_base  = req_count;
      send_restart(START_PC);
      wait_for_fill(req_base, START_PC);
      wait_for_pops(12);

      test_name = "jump_redirect";
      wait_for_pops(40); // several passes around the jal/j loop

      test_name  = "back_pressure";
      ack_enable = 1'b0;
      repeat (40) @(negedge clk);
      assert (insn_valid) else report_error("queue empty after holding acks low");
      ack_enable = 1'b1;
      wait_for_pops(40);

      test_name    = "warm_restart";
      hit_expected = 1'b1;
      send_restart(START_PC);
      wait_for_pops(30);
      hit_expected = 1'b0;

      test_name  = "flush";
      ack_enable = 1'b0;
      @(negedge clk);
      flush_req = 1'b1;
      @(negedge clk);
      flush_req = 1'b0;
      wait_for_flush_done();
      req_base = req_count;
      send_restart(START_PC);
      wait_for_fill(req_base, START_PC); // line was invalidated
      wait_for_pops(30);

      if (jal_pops != 0 && j_pops != 0)
      begin
         $display("TB PASSED");
         $finish;
      end
      else
      begin
         report_error("jal and j entries never reached the queue output");
      end
   end

endmodule

// ==== sim.f ====
+incdir+common
common/insn_pkg.sv
common/mem_pkg.sv
icache/predecode.sv
icache/icache_arrays.sv
rtl/fetch_queue.sv
rtl/fetch_ctrl.sv
rtl/l1i_fetch.sv
verification/tb_l1i_fetch.sv
